//--- hdl/atom_pkg.sv
// Atom system glue shared definitions
// Bus types, decoded regions, arbiter states and divider constants
package atom_pkg;

   // ==============================
   // Bus and port types
   // ==============================

   // CPU address and data
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  byte_t;

   // Video RAM word address
   typedef logic [12:0] vaddr_t;

   // Speed select: 0 = 1 MHz, 1 = 2 MHz, 2/3 = 4 MHz
   typedef logic [1:0]  turbo_t;

   // Decoded bus target
   typedef enum logic [2:0] {
      REG_RAM,
      REG_VIDEO,
      REG_PIA,
      REG_EMPTY,
      REG_ROM
   } region_t;

   // Video RAM read port arbiter
   typedef enum logic [1:0] {
      VS_IDLE,
      VS_CHECK,
      VS_CPU_ADDR,
      VS_CPU_CAPTURE
   } vid_state_t;

   // ==============================
   // Address map
   // ==============================

   localparam addr_t VIDEO_LO    = 16'h8000;
   localparam addr_t VIDEO_HI    = 16'h97FF;
   localparam addr_t ROM_BASE    = 16'hC000;
   // 16-byte blocks, compared against addr[15:4]
   localparam logic [11:0] PIA_BLOCK   = 12'hB00;
   localparam logic [11:0] EMPTY_BLOCK = 12'hB40;

   // Lock flag lives in bit 5 of zero page E7
   localparam addr_t LOCK_ADDR = 16'h00E7;
   localparam int    LOCK_BIT  = 5;

   // ==============================
   // Dividers and sizes
   // ==============================

   // 25 MHz down to a 1 MHz frame
   localparam int CLKDIV_LAST  = 24;
   localparam int CLKDIV_BITS  = $clog2(CLKDIV_LAST + 1);
   localparam int PWRUP_BITS   = 10;
   // 208 CPU ticks per cassette tone half period
   localparam int CAS_DIV_LAST = 207;
   localparam int CAS_DIV_BITS = $clog2(CAS_DIV_LAST + 1);
   localparam int VRAM_DEPTH   = 8192;

endpackage

//--- hdl/clock_enables.sv
// Clock enables and reset generation
// Turbo-selected CPU enable from a divide-by-25 counter, write gate,
// power-up counter and the combined system reset
`timescale 1ns/1ps

module clock_enables
   import atom_pkg::*;
(
   input  logic   clk25,
   input  logic   reset,
   input  logic   reset_sw,
   input  turbo_t turbo,
   output logic   cpu_clken,
   output logic   wegate_n,
   output logic   sys_reset,
   output logic   reset_led
);

   logic [CLKDIV_BITS-1:0] div_cnt;
   logic                   clken_next;
   logic                   clken_d;
   logic [PWRUP_BITS-1:0]  pwr_cnt;
   logic                   pwr_full;
   logic                   hard_reset;

   // ==============================
   // Divider and CPU enable
   // ==============================

   // Pulse positions within the 25-count frame
   always_comb
   begin
      case (turbo)
         2'd0:    clken_next = (div_cnt == '0);
         2'd1:    clken_next = (div_cnt[2:0] == 3'd0) && !div_cnt[4];
         default: clken_next = (div_cnt[1:0] == 2'd0) && !div_cnt[4];
      endcase
   end

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         div_cnt   <= '0;
         cpu_clken <= 1'b0;
         clken_d   <= 1'b0;
         wegate_n  <= 1'b1;
      end
      else
      begin
         if (div_cnt == CLKDIV_BITS'(CLKDIV_LAST))
            div_cnt <= '0;
         else
            div_cnt <= div_cnt + 1'b1;
         cpu_clken <= clken_next;
         // Gate opens one cycle after the bus settles
         clken_d   <= cpu_clken;
         wegate_n  <= !clken_d;
      end
   end

   // ==============================
   // Reset sources
   // ==============================

   assign pwr_full = &pwr_cnt;

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         pwr_cnt    <= '0;
         hard_reset <= 1'b1;
      end
      else if (cpu_clken)
      begin
         if (!pwr_full)
            pwr_cnt <= pwr_cnt + 1'b1;
         // Switch is active low
         hard_reset <= !reset_sw || !pwr_full;
      end
   end

   // Input reset acts at once
   assign sys_reset = reset || hard_reset;

   // Red LED follows reset
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         reset_led <= 1'b1;
      else
         reset_led <= sys_reset;
   end

endmodule

//--- hdl/bus_control.sv
// System bus control
// Registers the CPU bus, decodes regions, muxes read data,
// drives external RAM strobes and snoops the lock flag
`timescale 1ns/1ps

module bus_control
   import atom_pkg::*;
(
   input  logic  clk25,
   input  logic  reset,
   input  logic  cpu_clken,
   input  logic  wegate_n,
   input  addr_t cpu_addr,
   input  byte_t cpu_wdata,
   input  logic  cpu_we,
   input  byte_t pia_dout,
   input  byte_t vid_cpu_data,
   input  byte_t ram_rdata,
   output addr_t bus_addr,
   output byte_t bus_wdata,
   output logic  bus_write,
   output logic  pia_sel,
   output logic  video_sel,
   output byte_t cpu_din,
   output addr_t ram_addr,
   output byte_t ram_wdata,
   output logic  ram_we_n,
   output logic  ram_oe_n,
   output logic  lock
);

   region_t region;

   // ==============================
   // Bus register
   // ==============================

   // Address and data
   always_ff @(posedge clk25)
   begin
      if (cpu_clken)
      begin
         bus_addr  <= cpu_addr;
         bus_wdata <= cpu_wdata;
      end
   end

   // Direction
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         bus_write <= 1'b0;
      else if (cpu_clken)
         bus_write <= cpu_we;
   end

   // ==============================
   // Address decode
   // ==============================

   // Dropped chip selects fall through to RAM
   always_comb
   begin
      if (bus_addr >= VIDEO_LO && bus_addr <= VIDEO_HI)
         region = REG_VIDEO;
      else if (bus_addr[15:4] == PIA_BLOCK)
         region = REG_PIA;
      else if (bus_addr[15:4] == EMPTY_BLOCK)
         region = REG_EMPTY;
      else if (bus_addr >= ROM_BASE)
         region = REG_ROM;
      else
         region = REG_RAM;
   end

   assign pia_sel   = (region == REG_PIA);
   assign video_sel = (region == REG_VIDEO);

   // Read mux, ROM is served by external RAM
   always_comb
   begin
      case (region)
         REG_VIDEO: cpu_din = vid_cpu_data;
         REG_PIA:   cpu_din = pia_dout;
         REG_EMPTY: cpu_din = '0;
         default:   cpu_din = ram_rdata;
      endcase
   end

   // ==============================
   // External RAM
   // ==============================

   assign ram_addr  = bus_addr;
   assign ram_wdata = bus_wdata;
   assign ram_oe_n  = bus_write;
   // Writes above C000 are masked
   assign ram_we_n  = !(bus_write && !wegate_n && (region != REG_ROM));

   // Lock flag snoop
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         lock <= 1'b0;
      else if (cpu_clken && bus_write && bus_addr == LOCK_ADDR)
         lock <= bus_wdata[LOCK_BIT];
   end

endmodule

//--- hdl/pia_8255.sv
// 8255 PIA register model
// Fixed-direction ports A, B and C, plus the cassette tone
// divider and the cassette output gate
`timescale 1ns/1ps

module pia_8255
   import atom_pkg::*;
(
   input  logic       clk25,
   input  logic       reset,
   input  logic       cpu_clken,
   input  addr_t      bus_addr,
   input  byte_t      bus_wdata,
   input  logic       bus_write,
   input  logic       pia_sel,
   input  byte_t      pia_pb,
   input  logic       fs_n,
   input  logic       rept_n,
   input  logic       cas_in,
   output byte_t      pia_dout,
   output byte_t      pia_pa,
   output logic [3:0] pia_pc_out,
   output logic       cas_out
);

   byte_t                   pa_r;
   logic [3:0]              pc_r;
   byte_t                   pc_full;
   logic [CAS_DIV_BITS-1:0] cas_div;
   logic                    cas_tone;

   // ==============================
   // Port registers
   // ==============================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         pa_r <= '0;
         pc_r <= '0;
      end
      else if (cpu_clken && pia_sel && bus_write)
      begin
         case (bus_addr[1:0])
            2'd0: pa_r <= bus_wdata;
            2'd2: pc_r <= bus_wdata[3:0];
            2'd3:
            begin
               // Bit set/reset word, mode words ignored
               // Selects 4 to 7 are the input half
               if (!bus_wdata[7] && !bus_wdata[3])
                  pc_r[bus_wdata[2:1]] <= bus_wdata[0];
            end
            default: ;
         endcase
      end
   end

   assign pia_pa     = pa_r;
   assign pia_pc_out = pc_r;

   // Upper nibble is inputs and tone
   assign pc_full = {fs_n, rept_n, cas_in, cas_tone, pc_r};

   // Read back
   always_comb
   begin
      case (bus_addr[1:0])
         2'd0:    pia_dout = pa_r;
         2'd1:    pia_dout = pia_pb;
         2'd2:    pia_dout = pc_full;
         default: pia_dout = '0;
      endcase
   end

   // ==============================
   // Cassette
   // ==============================

   // Tone toggles every 208 CPU ticks
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cas_div  <= '0;
         cas_tone <= 1'b0;
      end
      else if (cpu_clken)
      begin
         if (cas_div == CAS_DIV_BITS'(CAS_DIV_LAST))
         begin
            cas_div  <= '0;
            cas_tone <= !cas_tone;
         end
         else
            cas_div <= cas_div + 1'b1;
      end
   end

   // Two NANDs and an inverter in the original
   assign cas_out = !pc_r[0] || (pc_r[1] && !cas_tone);

endmodule

//--- hdl/video_ram_share.sv
// Shared video RAM
// CPU write port plus one read port shared by CPU and display,
// CPU reads win through a small arbiter
`timescale 1ns/1ps

module video_ram_share
   import atom_pkg::*;
(
   input  logic   clk25,
   input  logic   reset,
   input  logic   cpu_clken,
   input  addr_t  bus_addr,
   input  byte_t  bus_wdata,
   input  logic   bus_write,
   input  logic   video_sel,
   input  vaddr_t video_addr,
   output byte_t  video_data,
   output byte_t  vid_cpu_data
);

   byte_t      vram [VRAM_DEPTH];
   vaddr_t     cpu_vaddr;
   vaddr_t     rd_addr;
   byte_t      rd_data;
   vid_state_t state;
   vid_state_t state_next;

   assign cpu_vaddr = bus_addr[12:0];

   // ==============================
   // Memory
   // ==============================

   // CPU write commits on the clock enable
   always_ff @(posedge clk25)
   begin
      if (cpu_clken && video_sel && bus_write)
         vram[cpu_vaddr] <= bus_wdata;
   end

   // Read port belongs to the CPU for one slot
   assign rd_addr = (state == VS_CPU_ADDR) ? cpu_vaddr : video_addr;

   always_ff @(posedge clk25)
   begin
      rd_data <= vram[rd_addr];
   end

   // ==============================
   // Arbiter
   // ==============================

   always_comb
   begin
      state_next = state;
      case (state)
         VS_IDLE:
         begin
            if (cpu_clken)
               state_next = VS_CHECK;
         end
         VS_CHECK:
         begin
            // Only CPU video reads take the port
            if (video_sel && !bus_write)
               state_next = VS_CPU_ADDR;
            else
               state_next = VS_IDLE;
         end
         VS_CPU_ADDR:    state_next = VS_CPU_CAPTURE;
         VS_CPU_CAPTURE: state_next = VS_IDLE;
         default:        state_next = VS_IDLE;
      endcase
   end

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         state <= VS_IDLE;
      else
         state <= state_next;
   end

   // Holding registers
   always_ff @(posedge clk25)
   begin
      if (state == VS_CPU_CAPTURE)
         vid_cpu_data <= rd_data;
      else
         video_data <= rd_data;
   end

endmodule

//--- hdl/atom_core.sv
// Atom system glue top level
// Clock enables, bus control, PIA and shared video RAM
`timescale 1ns/1ps

module atom_core
   import atom_pkg::*;
(
   input  logic       clk25,
   input  logic       reset,
   input  logic       reset_sw,
   input  turbo_t     turbo,
   output logic       cpu_clken,
   output logic       reset_led,
   // CPU side
   input  addr_t      cpu_addr,
   input  byte_t      cpu_wdata,
   input  logic       cpu_we,
   output byte_t      cpu_din,
   output logic       lock,
   // External RAM
   input  byte_t      ram_rdata,
   output addr_t      ram_addr,
   output byte_t      ram_wdata,
   output logic       ram_we_n,
   output logic       ram_oe_n,
   // PIA ports and cassette
   input  byte_t      pia_pb,
   input  logic       fs_n,
   input  logic       rept_n,
   input  logic       cas_in,
   output byte_t      pia_pa,
   output logic [3:0] pia_pc_out,
   output logic       cas_out,
   // Display fetch
   input  vaddr_t     video_addr,
   output byte_t      video_data
);

   logic  wegate_n;
   logic  sys_reset;
   addr_t bus_addr;
   byte_t bus_wdata;
   logic  bus_write;
   logic  pia_sel;
   logic  video_sel;
   byte_t pia_dout;
   byte_t vid_cpu_data;

   clock_enables i_clock_enables (
      .clk25     (clk25),
      .reset     (reset),
      .reset_sw  (reset_sw),
      .turbo     (turbo),
      .cpu_clken (cpu_clken),
      .wegate_n  (wegate_n),
      .sys_reset (sys_reset),
      .reset_led (reset_led)
   );

   bus_control i_bus_control (
      .clk25        (clk25),
      .reset        (sys_reset),
      .cpu_clken    (cpu_clken),
      .wegate_n     (wegate_n),
      .cpu_addr     (cpu_addr),
      .cpu_wdata    (cpu_wdata),
      .cpu_we       (cpu_we),
      .pia_dout     (pia_dout),
      .vid_cpu_data (vid_cpu_data),
      .ram_rdata    (ram_rdata),
      .bus_addr     (bus_addr),
      .bus_wdata    (bus_wdata),
      .bus_write    (bus_write),
      .pia_sel      (pia_sel),
      .video_sel    (video_sel),
      .cpu_din      (cpu_din),
      .ram_addr     (ram_addr),
      .ram_wdata    (ram_wdata),
      .ram_we_n     (ram_we_n),
      .ram_oe_n     (ram_oe_n),
      .lock         (lock)
   );

   pia_8255 i_pia_8255 (
      .clk25      (clk25),
      .reset      (sys_reset),
      .cpu_clken  (cpu_clken),
      .bus_addr   (bus_addr),
      .bus_wdata  (bus_wdata),
      .bus_write  (bus_write),
      .pia_sel    (pia_sel),
      .pia_pb     (pia_pb),
      .fs_n       (fs_n),
      .rept_n     (rept_n),
      .cas_in     (cas_in),
      .pia_dout   (pia_dout),
      .pia_pa     (pia_pa),
      .pia_pc_out (pia_pc_out),
      .cas_out    (cas_out)
   );

   video_ram_share i_video_ram_share (
      .clk25        (clk25),
      .reset        (sys_reset),
      .cpu_clken    (cpu_clken),
      .bus_addr     (bus_addr),
      .bus_wdata    (bus_wdata),
      .bus_write    (bus_write),
      .video_sel    (video_sel),
      .video_addr   (video_addr),
      .video_data   (video_data),
      .vid_cpu_data (vid_cpu_data)
   );

endmodule

//--- verif/atom_core_sva.sv
// Bound checks for the Atom system glue
// Enable spacing, ROM write mask, reset values and cassette gate
`timescale 1ns/1ps

module atom_core_sva
   import atom_pkg::*;
(
   input logic       clk25,
   input logic       reset,
   input logic       sys_reset,
   input turbo_t     turbo,
   input logic       cpu_clken,
   input logic       ram_we_n,
   input addr_t      ram_addr,
   input logic       lock,
   input byte_t      pia_pa,
   input logic [3:0] pia_pc_out,
   input logic       cas_out
);

   int fail_count = 0;

   // 1 MHz enable repeats every 25 cycles
   clken_spacing: assert property (@(posedge clk25) disable iff (reset || turbo != 2'd0)
      cpu_clken && $past(turbo) == 2'd0 |=> !cpu_clken [*24] ##1 cpu_clken)
   else
   begin
      $error("cpu_clken pulses at turbo 0 are not 25 cycles apart");
      fail_count++;
   end

   // No RAM write strobe in the ROM area
   rom_masked: assert property (@(posedge clk25) !ram_we_n |-> ram_addr < ROM_BASE)
   else
   begin
      $error("ram_we_n went low at %h", ram_addr);
      fail_count++;
   end

   // Reset state
   reset_values: assert property (@(posedge clk25)
      sys_reset |-> ram_we_n && !lock && pia_pa == '0 && pia_pc_out == '0)
   else
   begin
      $error("ram_we_n, lock or PIA outputs active during reset");
      fail_count++;
   end

   // Bit 0 low forces the output high
   cas_idle: assert property (@(posedge clk25) !pia_pc_out[0] |-> cas_out)
   else
   begin
      $error("cas_out low while port C bit 0 is clear");
      fail_count++;
   end

endmodule

bind atom_core atom_core_sva i_atom_core_sva (
   .clk25      (clk25),
   .reset      (reset),
   .sys_reset  (sys_reset),
   .turbo      (turbo),
   .cpu_clken  (cpu_clken),
   .ram_we_n   (ram_we_n),
   .ram_addr   (ram_addr),
   .lock       (lock),
   .pia_pa     (pia_pa),
   .pia_pc_out (pia_pc_out),
   .cas_out    (cas_out)
);

//--- verif/atom_core_tb.sv
// Testbench for the Atom system glue
// Plays the CPU on the registered bus, models the external RAM and
// walks through clock enables, RAM, PIA, video RAM, cassette and lock
`timescale 1ns/1ps

module atom_core_tb
   import atom_pkg::*;
();

   localparam int CLKEN_LIMIT  = 200;
   localparam int PWRUP_LIMIT  = 10000;
   localparam int TONE_LIMIT   = 4000;
   localparam int VIDEO_LIMIT  = 8;

   logic       clk25;
   logic       reset;
   logic       reset_sw;
   turbo_t     turbo;
   logic       cpu_clken;
   logic       reset_led;
   addr_t      cpu_addr;
   byte_t      cpu_wdata;
   logic       cpu_we;
   byte_t      cpu_din;
   logic       lock;
   byte_t      ram_rdata;
   addr_t      ram_addr;
   byte_t      ram_wdata;
   logic       ram_we_n;
   logic       ram_oe_n;
   byte_t      pia_pb;
   logic       fs_n;
   logic       rept_n;
   logic       cas_in;
   byte_t      pia_pa;
   logic [3:0] pia_pc_out;
   logic       cas_out;
   vaddr_t     video_addr;
   byte_t      video_data;

   byte_t ram_model [65536];
   int    errors;

   atom_core i_atom_core (.*);

   // ==============================
   // Clock and RAM model
   // ==============================

   initial
   begin
      clk25 = 1'b0;
      forever #20 clk25 = !clk25;
   end

   // Fill mixes both address bytes
   initial
   begin
      for (int a = 0; a < 65536; a++)
         ram_model[a] = byte_t'(a ^ (a >> 8)) ^ 8'hA5;
   end

   assign ram_rdata = ram_model[ram_addr];

   // Write strobe is low across one falling edge
   always @(negedge clk25)
   begin
      if (!ram_we_n)
         ram_model[ram_addr] <= ram_wdata;
   end

   // ==============================
   // Helpers
   // ==============================

   task automatic finish_run();
      int sva_fails;
      sva_fails = i_atom_core.i_atom_core_sva.fail_count;
      $display("Closing report: %0d testbench errors, %0d assertion failures",
               errors, sva_fails);
      if (errors == 0 && sva_fails == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   endtask

   task automatic check_byte(input string name, input byte_t got, input byte_t exp);
      assert (got === exp)
      else
      begin
         $display("FAILED at %0t: %s is %02h, expected %02h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Next falling edge inside a clock enable pulse
   task automatic wait_clken();
      int n;
      n = 0;
      do
      begin
         @(negedge clk25);
         n++;
      end
      while (!cpu_clken && n < CLKEN_LIMIT);
      if (!cpu_clken)
      begin
         $display("Timeout: no CPU clock enable within %0d cycles", CLKEN_LIMIT);
         errors++;
      end
   endtask

   // Idle read of zero page
   task automatic park_bus();
      cpu_addr  = '0;
      cpu_wdata = '0;
      cpu_we    = 1'b0;
   endtask

   task automatic cpu_write(input addr_t addr, input byte_t data);
      wait_clken();
      cpu_addr  = addr;
      cpu_wdata = data;
      cpu_we    = 1'b1;
      wait_clken();
      // Output enable off for the whole write cycle
      check_byte("ram_oe_n", byte_t'(ram_oe_n), 8'h01);
      park_bus();
      // Commit edge
      @(negedge clk25);
   endtask

   // Data is sampled just before the next enable
   task automatic cpu_read(input addr_t addr, output byte_t data);
      wait_clken();
      cpu_addr = addr;
      cpu_we   = 1'b0;
      wait_clken();
      data = cpu_din;
      check_byte("ram_oe_n", byte_t'(ram_oe_n), 8'h00);
      park_bus();
   endtask

   task automatic check_rate(input turbo_t speed, input int per_window);
      int pulses;
      turbo = speed;
      repeat (2) @(negedge clk25);
      pulses = 0;
      // Two full divider frames
      repeat (50)
      begin
         @(negedge clk25);
         if (cpu_clken)
            pulses++;
      end
      check_byte("cpu_clken pulses", byte_t'(pulses), byte_t'(2 * per_window));
   endtask

   task automatic wait_powerup();
      int n;
      n = 0;
      while (reset_led && n < PWRUP_LIMIT)
      begin
         @(negedge clk25);
         n++;
      end
      if (reset_led)
      begin
         $display("Timeout: power-up reset did not finish");
         errors++;
      end
   endtask

   // Clock enables between two tone edges
   task automatic measure_tone(output int ticks);
      logic prev;
      logic started;
      int   n;
      prev    = cas_out;
      started = 1'b0;
      ticks   = 0;
      for (n = 0; n < TONE_LIMIT; n++)
      begin
         @(negedge clk25);
         if (cas_out != prev)
         begin
            if (started)
               break;
            started = 1'b1;
            prev    = cas_out;
            ticks   = 0;
         end
         else if (started && cpu_clken)
            ticks++;
      end
      if (n == TONE_LIMIT)
      begin
         $display("Timeout: cassette output did not toggle twice");
         errors++;
      end
   endtask

   // ==============================
   // Stimulus
   // ==============================

   initial
   begin
      byte_t data;
      byte_t got;
      byte_t pc_exp;
      addr_t addr;
      int    i;
      int    n;
      int    ticks;
      void'($urandom(84836));
      errors     = 0;
      reset      = 1'b1;
      reset_sw   = 1'b1;
      turbo      = 2'd2;
      park_bus();
      pia_pb     = '0;
      fs_n       = 1'b1;
      rept_n     = 1'b1;
      cas_in     = 1'b0;
      video_addr = '0;
      repeat (4) @(negedge clk25);
      reset = 1'b0;
      wait_powerup();

      // Enable rates per turbo setting
      check_rate(2'd0, 1);
      check_rate(2'd1, 2);
      check_rate(2'd3, 4);
      check_rate(2'd2, 4);

      // RAM below video area
      for (i = 0; i < 8; i++)
      begin
         addr = addr_t'($urandom) & 16'h7FFF;
         data = byte_t'($urandom);
         cpu_write(addr, data);
         check_byte("ram_model", ram_model[addr], data);
         cpu_read(addr, got);
         check_byte("cpu_din", got, data);
      end
      // ROM area keeps its contents
      for (i = 0; i < 4; i++)
      begin
         addr = addr_t'($urandom) | 16'hC000;
         data = ram_model[addr];
         cpu_write(addr, ~data);
         check_byte("ram_model", ram_model[addr], data);
         cpu_read(addr, got);
         check_byte("cpu_din", got, data);
      end

      // PIA port A
      data = byte_t'($urandom);
      cpu_write(16'hB000, data);
      check_byte("pia_pa", pia_pa, data);
      cpu_read(16'hB000, got);
      check_byte("cpu_din", got, data);
      // Port C bit set and reset
      cpu_write(16'hB002, 8'h00);
      pc_exp = 8'h00;
      for (i = 0; i < 4; i++)
      begin
         cpu_write(16'hB003, byte_t'((i << 1) | 1));
         pc_exp[i] = 1'b1;
         check_byte("pia_pc_out", byte_t'(pia_pc_out), pc_exp);
      end
      cpu_write(16'hB003, 8'h04);
      pc_exp[2] = 1'b0;
      check_byte("pia_pc_out", byte_t'(pia_pc_out), pc_exp);
      // Mode word leaves port C alone
      cpu_write(16'hB003, 8'h81);
      check_byte("pia_pc_out", byte_t'(pia_pc_out), pc_exp);
      // Clearing input bit 4 leaves the output nibble alone
      cpu_write(16'hB003, 8'h08);
      check_byte("pia_pc_out", byte_t'(pia_pc_out), pc_exp);
      // Port B input
      pia_pb = byte_t'($urandom);
      cpu_read(16'hB001, got);
      check_byte("cpu_din", got, pia_pb);
      // Port C inputs, tone bit masked
      for (i = 0; i < 2; i++)
      begin
         {fs_n, rept_n, cas_in} = (i == 0) ? 3'b010 : 3'b101;
         cpu_read(16'hB002, got);
         check_byte("cpu_din", got & 8'hEF, {fs_n, rept_n, cas_in, 1'b0, pc_exp[3:0]});
      end

      // Lock snoop
      cpu_write(LOCK_ADDR, 8'h20);
      check_byte("lock", byte_t'(lock), 8'h01);
      cpu_write(LOCK_ADDR, 8'hDF);
      check_byte("lock", byte_t'(lock), 8'h00);

      // Video RAM at 2 MHz
      turbo = 2'd1;
      for (i = 0; i < 3; i++)
      begin
         addr = 16'h8000 | (addr_t'($urandom) & 16'h17FF);
         data = byte_t'($urandom);
         cpu_write(addr, data);
         cpu_read(addr, got);
         check_byte("cpu_din", got, data);
         video_addr = addr[12:0];
         n = 0;
         while (video_data !== data && n < VIDEO_LIMIT)
         begin
            @(negedge clk25);
            n++;
         end
         check_byte("video_data", video_data, data);
      end
      cpu_read(16'hB400, got);
      check_byte("cpu_din", got, 8'h00);

      // Cassette tone at 4 MHz
      turbo = 2'd2;
      cpu_write(16'hB002, 8'h03);
      measure_tone(ticks);
      check_byte("cas_out half period", byte_t'(ticks), 8'd208);
      cpu_write(16'hB003, 8'h00);
      repeat (300) @(negedge clk25);
      check_byte("cas_out", byte_t'(cas_out), 8'h01);

      // Reset pulse clears lock and PIA outputs
      cpu_write(LOCK_ADDR, 8'hFF);
      cpu_write(16'hB000, 8'h5A);
      cpu_write(16'hB002, 8'h0F);
      reset = 1'b1;
      repeat (4) @(negedge clk25);
      check_byte("lock", byte_t'(lock), 8'h00);
      check_byte("pia_pa", pia_pa, 8'h00);
      check_byte("pia_pc_out", byte_t'(pia_pc_out), 8'h00);
      check_byte("reset_led", byte_t'(reset_led), 8'h01);
      reset = 1'b0;
      @(negedge clk25);
      check_byte("lock", byte_t'(lock), 8'h00);
      check_byte("pia_pa", pia_pa, 8'h00);
      // Power-up count starts over
      check_byte("reset_led", byte_t'(reset_led), 8'h01);

      finish_run();
   end

endmodule

//--- sim.f
hdl/atom_pkg.sv
hdl/clock_enables.sv
hdl/bus_control.sv
hdl/pia_8255.sv
hdl/video_ram_share.sv
hdl/atom_core.sv
verif/atom_core_sva.sv
verif/atom_core_tb.sv

//--- Bender.yml
package:
  name: atom_core

sources:
  - hdl/atom_pkg.sv
  - hdl/clock_enables.sv
  - hdl/bus_control.sv
  - hdl/pia_8255.sv
  - hdl/video_ram_share.sv
  - hdl/atom_core.sv
  - target: simulation
    files:
      - verif/atom_core_sva.sv
      - verif/atom_core_tb.sv
